//--- isaPkg.sv
package isaPkg;

	// field widths of the 32-bit instruction word
	localparam int opWidth = 12;
	localparam int regWidth = 5;
	localparam int offWidth = 10;

	// pc counts words, not bytes
	localparam int pcWidth = 20;

	// one word step for sequential fetch
	localparam logic [pcWidth-1:0] pcStep = {{(pcWidth-1){1'b0}}, 1'b1};

	// opcodes the branch block cares about
	localparam logic [opWidth-1:0] opBeq = 12'h004;
	localparam logic [opWidth-1:0] opBne = 12'h005;
	localparam logic [opWidth-1:0] opJmp = 12'h002;

	// conditional branch: compare rs/rt, pc-relative word offset
	typedef struct packed {
		logic [opWidth-1:0] opcode;
		logic [regWidth-1:0] rs;
		logic [regWidth-1:0] rt;
		logic signed [offWidth-1:0] offset;
	} branchFmtT;

	// jump: absolute word target
	typedef struct packed {
		logic [opWidth-1:0] opcode;
		logic [pcWidth-1:0] target;
	} jumpFmtT;

	// same word, two views; opcode sits in the top bits of both
	typedef union packed {
		branchFmtT branchFmt;
		jumpFmtT jumpFmt;
	} instrWord;

endpackage

//--- bpPkg.sv
package bpPkg;

	// 2-bit saturating counter states
	// high bit is the prediction
	typedef enum logic [1:0] {
		strongNot = 2'b00,
		weakNot = 2'b01,
		weakTaken = 2'b10,
		strongTaken = 2'b11
	} counterState;

	// what the ID word turned out to be
	typedef enum logic [1:0] {
		kindNone = 2'b00,
		kindCond = 2'b01,
		kindJump = 2'b10
	} branchKind;

	// counter reset value
	localparam counterState counterInit = strongNot;

endpackage

//--- branchIfs.sv
`timescale 1ns/1ps

// lookup bus between ID decode and the counter table
interface predictIf #(
	parameter int indexBits = 4
);
	// one-cycle lookup request
	logic lookup;
	// low pc bits pick the counter
	logic [indexBits-1:0] index;
	bpPkg::branchKind kind;
	// comb answer, same cycle as lookup
	logic predictTaken;

	modport decoder (
		output lookup,
		output index,
		output kind,
		input predictTaken
	);

	modport predictor (
		input lookup,
		input index,
		input kind,
		output predictTaken
	);
endinterface

// resolution bus from EX back to the table and fetch
interface resolveIf #(
	parameter int indexBits = 4
);
	// strobe, only for conditional items in EX
	logic update;
	logic [indexBits-1:0] index;
	logic actualTaken;
	// stored prediction did not match outcome
	logic wrong;

	modport source (
		output update,
		output index,
		output actualTaken,
		output wrong
	);

	modport sink (
		input update,
		input index,
		input actualTaken,
		input wrong
	);

	// fetch only needs to know a redirect is due
	modport monitor (
		input update,
		input wrong
	);
endinterface

//--- branchDecode.sv
`timescale 1ns/1ps

module branchDecode #(
	parameter int indexBits = 4
) (
	input logic idValid,
	input logic [isaPkg::pcWidth-1:0] idPc,
	input isaPkg::instrWord idInstr,
	input logic flush,
	predictIf.decoder pred,
	output logic [isaPkg::pcWidth-1:0] target,
	output bpPkg::branchKind kind
);

	logic [isaPkg::opWidth-1:0] opcode;
	logic [isaPkg::pcWidth-1:0] offsetExt;
	bpPkg::branchKind rawKind;

	// opcode field is common to both formats
	assign opcode = idInstr.branchFmt.opcode;

	// classify the word
	always_comb begin
		case (opcode)
			isaPkg::opBeq,
			isaPkg::opBne: rawKind = bpPkg::kindCond;
			isaPkg::opJmp: rawKind = bpPkg::kindJump;
			default: rawKind = bpPkg::kindNone;
		endcase
	end

	// no strobe, nothing to classify
	assign kind = idValid ? rawKind : bpPkg::kindNone;

	// sign extend the word offset up to pc width
	assign offsetExt = {
		{(isaPkg::pcWidth - isaPkg::offWidth){idInstr.branchFmt.offset[isaPkg::offWidth-1]}},
		idInstr.branchFmt.offset
	};

	// branch is relative to pc+1, jump is absolute
	always_comb begin
		if (rawKind == bpPkg::kindJump) begin
			target = idInstr.jumpFmt.target;
		end else begin
			target = idPc + isaPkg::pcStep + offsetExt;
		end
	end

	// wrong-path item during a redirect never looks up
	assign pred.lookup = idValid && !flush;
	assign pred.index = idPc[indexBits-1:0];
	assign pred.kind = kind;

endmodule

//--- branchPredictor.sv
`timescale 1ns/1ps

module branchPredictor #(
	parameter int indexBits = 4
) (
	input logic rst,
	input logic clk,
	predictIf.predictor pred,
	resolveIf.sink res
);

	localparam int tableSize = 2 ** indexBits;

	// one counter per low-pc slot
	bpPkg::counterState counters [tableSize];

	// counter step for one resolved branch
	function automatic bpPkg::counterState nextState(
		input bpPkg::counterState cur,
		input logic wrong,
		input logic taken
	);
		bpPkg::counterState nxt;
		nxt = cur;
		if (wrong) begin
			// wrong guess moves one step, weak states cross over
			case (cur)
				bpPkg::strongNot: nxt = bpPkg::weakNot;
				bpPkg::weakNot: nxt = bpPkg::weakTaken;
				bpPkg::weakTaken: nxt = bpPkg::weakNot;
				bpPkg::strongTaken: nxt = bpPkg::weakTaken;
				default: nxt = cur;
			endcase
		end else begin
			// right guess: settle into the strong state of that direction
			nxt = taken ? bpPkg::strongTaken : bpPkg::strongNot;
		end
		return nxt;
	endfunction

	// write at the end of the EX cycle
	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			for (int i = 0; i < tableSize; i++) begin
				counters[i] <= bpPkg::counterInit;
			end
		end else if (res.update) begin
			counters[res.index] <= nextState(counters[res.index], res.wrong, res.actualTaken);
		end
	end

	// comb read, so same-cycle lookup sees the old value
	// only conditional branches get a taken guess
	assign pred.predictTaken = pred.lookup
		&& (pred.kind == bpPkg::kindCond)
		&& counters[pred.index][1];

endmodule

//--- branchResolve.sv
`timescale 1ns/1ps

module branchResolve #(
	parameter int indexBits = 4
) (
	input logic rst,
	input logic clk,
	input logic idValid,
	input logic flush,
	input logic [isaPkg::pcWidth-1:0] idPc,
	input logic [isaPkg::pcWidth-1:0] target,
	input isaPkg::instrWord idInstr,
	input bpPkg::branchKind kind,
	input logic predictTaken,
	input logic [31:0] exRsValue,
	input logic [31:0] exRtValue,
	resolveIf.source res,
	output logic mispredict,
	output logic [isaPkg::pcWidth-1:0] redirectPc
);

	// ID/EX register
	logic exValid;
	logic [isaPkg::pcWidth-1:0] exPc;
	logic [isaPkg::pcWidth-1:0] exTarget;
	logic [isaPkg::opWidth-1:0] exOp;
	bpPkg::branchKind exKind;
	logic exPredict;

	logic isCond;
	logic actualTaken;
	logic goTarget;

	// squashed items never reach EX
	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			exValid <= 1'b0;
		end else begin
			exValid <= idValid && !flush;
		end
	end

	// payload, qualified by exValid
	always_ff @(posedge rst) begin
		exPc <= idPc;
		exTarget <= target;
		exOp <= idInstr.branchFmt.opcode;
		exKind <= kind;
		exPredict <= predictTaken;
	end

	assign isCond = exValid && (exKind == bpPkg::kindCond);

	// beq on equal, bne on not equal
	assign actualTaken = (exOp == isaPkg::opBeq) ? (exRsValue == exRtValue)
		: (exRsValue != exRtValue);

	// jumps were already steered in ID, never wrong
	assign mispredict = isCond && (actualTaken != exPredict);

	// correct next pc for the item in EX
	assign goTarget = (exKind == bpPkg::kindJump) || actualTaken;
	assign redirectPc = goTarget ? exTarget : exPc + isaPkg::pcStep;

	assign res.update = isCond;
	assign res.index = exPc[indexBits-1:0];
	assign res.actualTaken = actualTaken;
	assign res.wrong = mispredict;

endmodule

//--- fetchPcSelect.sv
`timescale 1ns/1ps

module fetchPcSelect (
	input logic rst,
	input logic clk,
	resolveIf.monitor res,
	input logic mispredict,
	input logic [isaPkg::pcWidth-1:0] redirectPc,
	input logic predictTaken,
	input bpPkg::branchKind kind,
	input logic [isaPkg::pcWidth-1:0] target,
	output logic [isaPkg::pcWidth-1:0] fetchPc
);

	logic [isaPkg::pcWidth-1:0] nextPc;
	logic redirect;
	logic idSteer;

	// EX reports a wrong conditional
	assign redirect = res.update && res.wrong;

	// ID item steers fetch only when it is on the right path
	assign idSteer = !mispredict && (predictTaken || (kind == bpPkg::kindJump));

	// priority: EX redirect, then ID target, then sequential
	always_comb begin
		if (redirect) begin
			nextPc = redirectPc;
		end else if (idSteer) begin
			nextPc = target;
		end else begin
			nextPc = fetchPc + isaPkg::pcStep;
		end
	end

	always_ff @(posedge rst or posedge clk) begin
		if (clk) begin
			fetchPc <= '0;
		end else begin
			fetchPc <= nextPc;
		end
	end

endmodule

//--- branchUnit.sv
`timescale 1ns/1ps

module branchUnit #(
	parameter int indexBits = 4
) (
	input logic rst,
	input logic clk,
	input logic idValid,
	input logic [isaPkg::pcWidth-1:0] idPc,
	input isaPkg::instrWord idInstr,
	input logic [31:0] exRsValue,
	input logic [31:0] exRtValue,
	output logic [isaPkg::pcWidth-1:0] fetchPc,
	output logic idPredictTaken,
	output logic mispredict,
	output logic [isaPkg::pcWidth-1:0] redirectPc
);

	// ID lookup and EX update buses
	predictIf #(.indexBits(indexBits)) predBus ();
	resolveIf #(.indexBits(indexBits)) resBus ();

	logic [isaPkg::pcWidth-1:0] idTarget;
	bpPkg::branchKind idKind;
	logic flush;

	// a redirect kills the ID item of the same cycle
	assign flush = mispredict;

	assign idPredictTaken = predBus.predictTaken;

	branchDecode #(.indexBits(indexBits)) i_branchDecode (
		.idValid(idValid),
		.idPc(idPc),
		.idInstr(idInstr),
		.flush(flush),
		.pred(predBus.decoder),
		.target(idTarget),
		.kind(idKind)
	);

	branchPredictor #(.indexBits(indexBits)) i_branchPredictor (
		.rst(rst),
		.clk(clk),
		.pred(predBus.predictor),
		.res(resBus.sink)
	);

	branchResolve #(.indexBits(indexBits)) i_branchResolve (
		.rst(rst),
		.clk(clk),
		.idValid(idValid),
		.flush(flush),
		.idPc(idPc),
		.target(idTarget),
		.idInstr(idInstr),
		.kind(idKind),
		.predictTaken(predBus.predictTaken),
		.exRsValue(exRsValue),
		.exRtValue(exRtValue),
		.res(resBus.source),
		.mispredict(mispredict),
		.redirectPc(redirectPc)
	);

	fetchPcSelect i_fetchPcSelect (
		.rst(rst),
		.clk(clk),
		.res(resBus.monitor),
		.mispredict(mispredict),
		.redirectPc(redirectPc),
		.predictTaken(predBus.predictTaken),
		.kind(idKind),
		.target(idTarget),
		.fetchPc(fetchPc)
	);

endmodule

//--- branchUnit_asserts.sv
`timescale 1ns/1ps

module branchUnit_asserts (
	input logic rst,
	input logic clk,
	input logic idValid,
	input logic mispredict,
	input logic [isaPkg::pcWidth-1:0] fetchPc,
	input logic [isaPkg::pcWidth-1:0] redirectPc
);

	// failures so far, read by the testbench top at the end
	int failCount = 0;

	// EX slot is empty while reset is held
	noMispredictInReset: assert property (@(posedge rst) clk |-> !mispredict)
		else begin
			failCount++;
			$error("mispredict high during reset");
		end

	// a resolution needs an ID strobe one cycle earlier
	mispredictAfterStrobe: assert property (@(posedge rst) disable iff (clk)
		mispredict |-> $past(idValid))
		else begin
			failCount++;
			$error("mispredict without an ID strobe in the previous cycle");
		end

	// fetch lands on the redirect target at the next edge
	fetchFollowsRedirect: assert property (@(posedge rst) disable iff (clk)
		mispredict |=> (fetchPc == $past(redirectPc)))
		else begin
			failCount++;
			$error("fetchPc did not take redirectPc after a mispredict");
		end

endmodule

//--- tbChecker.sv
`timescale 1ns/1ps

module tbChecker #(
	parameter int indexBits = 4
) (
	input logic rst,
	input logic clk,
	input logic idValid,
	input logic [isaPkg::pcWidth-1:0] idPc,
	input logic [31:0] idInstr,
	input logic [31:0] exRsValue,
	input logic [31:0] exRtValue,
	input logic [isaPkg::pcWidth-1:0] fetchPc,
	input logic idPredictTaken,
	input logic mispredict,
	input logic [isaPkg::pcWidth-1:0] redirectPc,
	output int errorCount,
	output int checkCount
);

	localparam int pcW = isaPkg::pcWidth;

	typedef struct packed {
		logic predict;
		logic mispredict;
		logic [pcW-1:0] redirect;
		logic [pcW-1:0] nextPc;
		logic taken;
	} expectT;

	// model state: own counter table, fetch pc, one EX slot
	bpPkg::counterState counters [2 ** indexBits];
	logic [pcW-1:0] pcModel;
	logic [pcW-1:0] exPcM;
	logic [pcW-1:0] exTgtM;
	logic exV, exBeq, exCond, exPred;

	// wrong guess steps once and weak states cross, right guess goes strong
	function automatic bpPkg::counterState counterStep(input bpPkg::counterState c,
			input logic wrong);
		case (c)
			bpPkg::strongNot: return wrong ? bpPkg::weakNot : bpPkg::strongNot;
			bpPkg::weakNot: return wrong ? bpPkg::weakTaken : bpPkg::strongNot;
			bpPkg::weakTaken: return wrong ? bpPkg::weakNot : bpPkg::strongTaken;
			default: return wrong ? bpPkg::weakTaken : bpPkg::strongTaken;
		endcase
	endfunction

	// jump is absolute, branch is pc+1 plus signed word offset
	function automatic logic [pcW-1:0] branchTarget(input logic [pcW-1:0] pc,
			input logic [31:0] instr);
		if (instr[31:20] == isaPkg::opJmp) begin
			return instr[19:0];
		end
		return pc + pcW'(1) + {{(pcW - 10){instr[9]}}, instr[9:0]};
	endfunction

	// reference: expected outputs for this cycle from model state and ports
	function automatic expectT expectedOutputs(input logic v, input logic [pcW-1:0] pc,
			input logic [31:0] instr, input logic [31:0] rs, input logic [31:0] rt);
		expectT e;
		logic cond;
		logic jump;
		cond = (instr[31:20] == isaPkg::opBeq) || (instr[31:20] == isaPkg::opBne);
		jump = instr[31:20] == isaPkg::opJmp;
		e.taken = exBeq ? (rs == rt) : (rs != rt);
		e.mispredict = exV && exCond && (e.taken != exPred);
		e.redirect = e.taken ? exTgtM : exPcM + pcW'(1);
		// lookup reads the table before this cycle's update
		e.predict = v && !e.mispredict && cond && counters[pc[indexBits-1:0]][1];
		if (e.mispredict) begin
			e.nextPc = e.redirect;
		end else if (e.predict || (v && jump)) begin
			e.nextPc = branchTarget(pc, instr);
		end else begin
			e.nextPc = pcModel + pcW'(1);
		end
		return e;
	endfunction

	task automatic compareValue(input string what, input logic [pcW-1:0] expv,
			input logic [pcW-1:0] got);
		checkCount++;
		if (got !== expv) begin
			errorCount++;
			$display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, what, expv, got);
		end
	endtask

	// mid-cycle sample, inputs and comb outputs are settled here
	always @(negedge rst) begin
		expectT e;
		if (clk) begin
			errorCount = 0;
			checkCount = 0;
			pcModel = '0;
			exV = 1'b0;
			foreach (counters[i]) begin
				counters[i] = bpPkg::strongNot;
			end
		end else begin
			e = expectedOutputs(idValid, idPc, idInstr, exRsValue, exRtValue);
			compareValue("fetchPc", pcModel, fetchPc);
			compareValue("idPredictTaken", pcW'(e.predict), pcW'(idPredictTaken));
			compareValue("mispredict", pcW'(e.mispredict), pcW'(mispredict));
			if (e.mispredict) begin
				compareValue("redirectPc", e.redirect, redirectPc);
			end
			// EX outcome trains its counter at the closing edge
			if (exV && exCond) begin
				counters[exPcM[indexBits-1:0]] = counterStep(counters[exPcM[indexBits-1:0]],
					e.mispredict);
			end
			// squashed ID item never reaches EX
			exV = idValid && !e.mispredict;
			exPcM = idPc;
			exTgtM = branchTarget(idPc, idInstr);
			exBeq = idInstr[31:20] == isaPkg::opBeq;
			exCond = exBeq || (idInstr[31:20] == isaPkg::opBne);
			exPred = e.predict;
			pcModel = e.nextPc;
		end
	end

endmodule

//--- tbBranchUnit.sv
`timescale 1ns/1ps

module tbBranchUnit;

	localparam int indexBits = 4;
	localparam int pcW = isaPkg::pcWidth;
	// five tests of well under 500 cycles each plus margin
	localparam int cycleLimit = 3000;

	logic rst;
	logic clk;
	logic idValid;
	logic [pcW-1:0] idPc;
	isaPkg::instrWord idInstr;
	logic [31:0] exRsValue;
	logic [31:0] exRtValue;
	logic [pcW-1:0] fetchPc;
	logic idPredictTaken;
	logic mispredict;
	logic [pcW-1:0] redirectPc;
	int errorCount;
	int checkCount;
	int cycleCount = 0;
	int testErrors;
	int assertFails;
	// operands for whatever sits in EX next cycle
	logic [31:0] pendRs = '0;
	logic [31:0] pendRt = '0;

	bind branchUnit branchUnit_asserts i_asserts (
		.rst(rst),
		.clk(clk),
		.idValid(idValid),
		.mispredict(mispredict),
		.fetchPc(fetchPc),
		.redirectPc(redirectPc)
	);

	branchUnit #(.indexBits(indexBits)) i_branchUnit (.*);

	tbChecker #(.indexBits(indexBits)) i_tbChecker (.*);

	// rst is the clock port here
	initial begin
		rst = 1'b0;
		forever #5 rst = ~rst;
	end

	always @(posedge rst) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("sim failed");
			$finish;
		end
	end

	// one ID slot with the EX operands of the item issued one step earlier
	task automatic driveStep(input logic v, input logic [pcW-1:0] pc, input logic [31:0] instr,
			input logic [31:0] rs, input logic [31:0] rt);
		@(posedge rst);
		#1;
		idValid = v;
		idPc = pc;
		idInstr = instr;
		exRsValue = pendRs;
		exRtValue = pendRt;
		pendRs = rs;
		pendRt = rt;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) driveStep(1'b0, '0, '0, '0, '0);
	endtask

	function automatic logic [31:0] branchWord(input logic [11:0] op, input logic [9:0] off);
		return {op, 5'd1, 5'd2, off};
	endfunction

	task automatic reportTest(input string name);
		@(negedge rst);
		#1;
		if (errorCount == testErrors) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d mismatches", name, errorCount - testErrors);
		end
		testErrors = errorCount;
	endtask

	task automatic sequentialFetch();
		// plain opcode so fetch just counts up
		for (int i = 0; i < 12; i++) begin
			driveStep(1'b1, pcW'(i), {12'h010, 20'(i)}, '0, '0);
		end
		idleCycles(2);
		reportTest("resetState");
	endtask

	task automatic counterWalk();
		// T T N T T N N N walks through all four states and back
		logic [7:0] outcome;
		outcome = 8'b0001_1011;
		for (int i = 0; i < 8; i++) begin
			driveStep(1'b1, 20'h00013, branchWord(isaPkg::opBeq, 10'h3f0), 32'h5,
				outcome[i] ? 32'h5 : 32'h6);
			idleCycles(1);
		end
		idleCycles(1);
		reportTest("counterWalk");
	endtask

	task automatic jumpRedirect();
		driveStep(1'b1, 20'h00100, {isaPkg::opJmp, 20'h12345}, '0, '0);
		idleCycles(3);
		driveStep(1'b1, 20'h00200, {isaPkg::opJmp, 20'h00040}, '0, '0);
		idleCycles(3);
		reportTest("jumps");
	endtask

	task automatic mispredictSquash();
		// bne at index 5 is predicted not taken and unequal operands make it taken
		driveStep(1'b1, 20'h00025, branchWord(isaPkg::opBne, 10'h010), 32'h1, 32'h2);
		// wrong-path beq at index 7 would train its counter if it got through
		driveStep(1'b1, 20'h00037, branchWord(isaPkg::opBeq, 10'h008), 32'h9, 32'h9);
		idleCycles(2);
		// later predictions at index 7 show whether that counter moved
		repeat (2) begin
			driveStep(1'b1, 20'h00037, branchWord(isaPkg::opBeq, 10'h008), 32'h9, 32'h9);
			idleCycles(1);
		end
		idleCycles(2);
		reportTest("mispredictSquash");
	endtask

	task automatic randomMix();
		logic [pcW-1:0] pc;
		logic [31:0] instr;
		logic [31:0] rs;
		logic [31:0] rt;
		logic v;
		for (int i = 0; i < 400; i++) begin
			v = $urandom_range(0, 3) != 0;
			pc = 20'($urandom);
			// half the pcs alias onto one counter
			if ($urandom_range(0, 1) == 1) begin
				pc[indexBits-1:0] = '1;
			end
			case ($urandom_range(0, 3))
				0: instr = {isaPkg::opBeq, 20'($urandom)};
				1: instr = {isaPkg::opBne, 20'($urandom)};
				2: instr = {isaPkg::opJmp, 20'($urandom)};
				default: instr = {12'h020, 20'($urandom)};
			endcase
			rs = $urandom;
			rt = ($urandom_range(0, 1) == 1) ? rs : $urandom;
			driveStep(v, pc, instr, rs, rt);
		end
		idleCycles(3);
		reportTest("randomMix");
	endtask

	initial begin
		void'($urandom(10));
		// clk is the active-high reset port
		clk = 1'b1;
		idValid = 1'b0;
		idPc = '0;
		idInstr = '0;
		exRsValue = '0;
		exRtValue = '0;
		testErrors = 0;
		repeat (5) @(posedge rst);
		#1;
		clk = 1'b0;
		sequentialFetch();
		counterWalk();
		jumpRedirect();
		mispredictSquash();
		randomMix();
		assertFails = i_branchUnit.i_asserts.failCount;
		$display("checks %0d, mismatches %0d, assertion failures %0d", checkCount, errorCount,
			assertFails);
		if (errorCount == 0 && assertFails == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

//--- all.f
isaPkg.sv
bpPkg.sv
branchIfs.sv
branchDecode.sv
branchPredictor.sv
branchResolve.sv
fetchPcSelect.sv
branchUnit.sv
branchUnit_asserts.sv
tbChecker.sv
tbBranchUnit.sv

//--- runSim.sh
#!/bin/sh
# build and run the branch unit testbench with Verilator

verilator --binary --assert --top-module tbBranchUnit -f all.f -o simBranchUnit
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/simBranchUnit +verilator+error+limit+1000)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit 1
fi

if echo "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
